//--- Bender.yml
package:
  name: gpgpu_mem

sources:
  - include_dirs:
      - src
    files:
      - src/l2_types_pkg.sv
      - src/pc_types_pkg.sv
      - src/l2_arbiter.sv
      - src/l2_ctrl_fsm.sv
      - src/burst_counter.sv
      - src/line_store.sv
      - src/performance_counters.sv
      - src/gpgpu_mem.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - verification/gpgpu_mem_checker.sv
      - verification/gpgpu_mem_tb.sv

//--- gpgpu_mem.f
+incdir+src
src/l2_types_pkg.sv
src/pc_types_pkg.sv
src/l2_arbiter.sv
src/l2_ctrl_fsm.sv
src/burst_counter.sv
src/line_store.sv
src/performance_counters.sv
src/gpgpu_mem.sv
verification/gpgpu_mem_checker.sv
verification/gpgpu_mem_tb.sv

//--- src/burst_counter.sv
// **************************************************
// Word index counter for one line burst
// **************************************************
`default_nettype none

`include "gpgpu_params.svh"

module burst_counter
(
	input wire logic reset, // Clock
	input wire logic clk, // Async reset, active high
	input wire logic burst_run, // Step one word per cycle
	output l2_types_pkg::word_index_t word_index,
	output logic burst_last // Final word of the line
);

	import l2_types_pkg::*;

	assign burst_last = (word_index == word_index_t'(`GPGPU_LINE_WORDS - 1));

	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
			word_index <= '0;
		else if (burst_run)
		begin
			if (burst_last)
				word_index <= '0; // Ready for the next line
			else
				word_index <= word_index + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- src/gpgpu_mem.sv
// **************************************************
// Memory side top: arbiter, L2 controller, burst
// counter, line store and performance counters
// **************************************************
`default_nettype none

module gpgpu_mem
(
	input wire logic reset, // Clock
	input wire logic clk, // Async reset, active high
	input wire logic l2req_valid0, // Core 0 request
	input wire l2_types_pkg::l2_op_t l2req_op0,
	input wire l2_types_pkg::line_addr_t l2req_address0,
	input wire l2_types_pkg::line_data_t l2req_data0,
	input wire l2_types_pkg::word_mask_t l2req_mask0,
	output logic l2req_ready0,
	input wire logic l2req_valid1, // Core 1 request
	input wire l2_types_pkg::l2_op_t l2req_op1,
	input wire l2_types_pkg::line_addr_t l2req_address1,
	input wire l2_types_pkg::line_data_t l2req_data1,
	input wire l2_types_pkg::word_mask_t l2req_mask1,
	output logic l2req_ready1,
	output logic l2rsp_valid, // Broadcast to both cores
	output l2_types_pkg::core_index_t l2rsp_core,
	output l2_types_pkg::l2_op_t l2rsp_op,
	output l2_types_pkg::line_addr_t l2rsp_address,
	output l2_types_pkg::line_data_t l2rsp_data,
	input wire pc_types_pkg::pc_index_t pc_select,
	output pc_types_pkg::pc_count_t pc_value
);

	import l2_types_pkg::*;

	// Arbitrated request
	logic l2req_valid;
	l2_op_t l2req_op;
	line_addr_t l2req_address;
	line_data_t l2req_data;
	word_mask_t l2req_mask;
	core_index_t l2req_core;
	logic l2req_ready;

	// Controller to burst counter and store
	logic burst_run;
	logic burst_last;
	word_index_t word_index;
	logic word_write_en;
	line_addr_t line_addr;
	line_data_t write_line;

	// Event strobes
	logic load_event;
	logic store_event;
	logic stall_event;

	l2_arbiter arbiter0
	(
		.reset(reset),
		.clk(clk),
		.l2req_valid0(l2req_valid0),
		.l2req_op0(l2req_op0),
		.l2req_address0(l2req_address0),
		.l2req_data0(l2req_data0),
		.l2req_mask0(l2req_mask0),
		.l2req_ready0(l2req_ready0),
		.l2req_valid1(l2req_valid1),
		.l2req_op1(l2req_op1),
		.l2req_address1(l2req_address1),
		.l2req_data1(l2req_data1),
		.l2req_mask1(l2req_mask1),
		.l2req_ready1(l2req_ready1),
		.l2req_ready(l2req_ready),
		.l2req_valid(l2req_valid),
		.l2req_op(l2req_op),
		.l2req_address(l2req_address),
		.l2req_data(l2req_data),
		.l2req_mask(l2req_mask),
		.l2req_core(l2req_core),
		.stall_event(stall_event)
	);

	l2_ctrl_fsm ctrl0
	(
		.reset(reset),
		.clk(clk),
		.l2req_valid(l2req_valid),
		.l2req_op(l2req_op),
		.l2req_address(l2req_address),
		.l2req_data(l2req_data),
		.l2req_mask(l2req_mask),
		.l2req_core(l2req_core),
		.word_index(word_index),
		.burst_last(burst_last),
		.l2req_ready(l2req_ready),
		.burst_run(burst_run),
		.word_write_en(word_write_en),
		.line_addr(line_addr),
		.write_line(write_line),
		.l2rsp_valid(l2rsp_valid),
		.l2rsp_core(l2rsp_core),
		.l2rsp_op(l2rsp_op),
		.l2rsp_address(l2rsp_address),
		.load_event(load_event),
		.store_event(store_event)
	);

	burst_counter burst0
	(
		.reset(reset),
		.clk(clk),
		.burst_run(burst_run),
		.word_index(word_index),
		.burst_last(burst_last)
	);

	line_store store0
	(
		.reset(reset),
		.clk(clk),
		.line_addr(line_addr),
		.word_index(word_index),
		.word_write_en(word_write_en),
		.write_line(write_line),
		.rsp_line(l2rsp_data)
	);

	// Order follows PC_STALL, PC_WORD_WRITE, PC_STORE, PC_LOAD
	performance_counters counters0
	(
		.reset(reset),
		.clk(clk),
		.pc_event({stall_event, word_write_en, store_event, load_event}),
		.pc_select(pc_select),
		.pc_value(pc_value)
	);

endmodule

`default_nettype wire

//--- src/gpgpu_params.svh
// **************************************************
// Memory geometry and performance counter sizes
// **************************************************
`ifndef GPGPU_PARAMS_SVH
`define GPGPU_PARAMS_SVH

// Line store geometry
`define GPGPU_NUM_LINES 16 // Lines in the store
`define GPGPU_LINE_WORDS 4 // Words per line
`define GPGPU_WORD_WIDTH 32 // Bits per word

// Performance counters
`define GPGPU_NUM_COUNTERS 4 // Loads, stores, words written, stalls
`define GPGPU_COUNTER_WIDTH 32 // Wraps at full width

`endif

//--- src/l2_arbiter.sv
// **************************************************
// Round-robin arbiter for the two core request ports
// **************************************************
`default_nettype none

module l2_arbiter
(
	input wire logic reset, // Clock
	input wire logic clk, // Async reset, active high
	input wire logic l2req_valid0,
	input wire l2_types_pkg::l2_op_t l2req_op0,
	input wire l2_types_pkg::line_addr_t l2req_address0,
	input wire l2_types_pkg::line_data_t l2req_data0,
	input wire l2_types_pkg::word_mask_t l2req_mask0,
	output logic l2req_ready0,
	input wire logic l2req_valid1,
	input wire l2_types_pkg::l2_op_t l2req_op1,
	input wire l2_types_pkg::line_addr_t l2req_address1,
	input wire l2_types_pkg::line_data_t l2req_data1,
	input wire l2_types_pkg::word_mask_t l2req_mask1,
	output logic l2req_ready1,
	input wire logic l2req_ready, // From controller, high in IDLE
	output logic l2req_valid,
	output l2_types_pkg::l2_op_t l2req_op,
	output l2_types_pkg::line_addr_t l2req_address,
	output l2_types_pkg::line_data_t l2req_data,
	output l2_types_pkg::word_mask_t l2req_mask,
	output l2_types_pkg::core_index_t l2req_core,
	output logic stall_event // Some core waiting this cycle
);

	import l2_types_pkg::*;

	core_index_t select_q; // Core currently offered to the controller

	assign l2req_core = select_q;
	assign l2req_valid = select_q ? l2req_valid1 : l2req_valid0;
	assign l2req_op = select_q ? l2req_op1 : l2req_op0;
	assign l2req_address = select_q ? l2req_address1 : l2req_address0;
	assign l2req_data = select_q ? l2req_data1 : l2req_data0;
	assign l2req_mask = select_q ? l2req_mask1 : l2req_mask0;

	// Only the selected core sees ready
	assign l2req_ready0 = !select_q && l2req_ready;
	assign l2req_ready1 = select_q && l2req_ready;

	// Counted once even with both cores held off
	assign stall_event = (l2req_valid0 && !l2req_ready0) || (l2req_valid1 && !l2req_ready1);

	// Rotate after a transfer or when the selected core is idle
	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
			select_q <= 1'b0; // Core 0 first
		else if (!l2req_valid || l2req_ready)
			select_q <= !select_q;
	end

endmodule

`default_nettype wire

//--- src/l2_ctrl_fsm.sv
// **************************************************
// L2 controller FSM: accept, word burst, response
// **************************************************
`default_nettype none

module l2_ctrl_fsm
(
	input wire logic reset, // Clock
	input wire logic clk, // Async reset, active high
	input wire logic l2req_valid,
	input wire l2_types_pkg::l2_op_t l2req_op,
	input wire l2_types_pkg::line_addr_t l2req_address,
	input wire l2_types_pkg::line_data_t l2req_data,
	input wire l2_types_pkg::word_mask_t l2req_mask,
	input wire l2_types_pkg::core_index_t l2req_core,
	input wire l2_types_pkg::word_index_t word_index, // Current burst word
	input wire logic burst_last, // Final word of the line
	output logic l2req_ready,
	output logic burst_run,
	output logic word_write_en,
	output l2_types_pkg::line_addr_t line_addr,
	output l2_types_pkg::line_data_t write_line, // Latched store data
	output logic l2rsp_valid,
	output l2_types_pkg::core_index_t l2rsp_core,
	output l2_types_pkg::l2_op_t l2rsp_op,
	output l2_types_pkg::line_addr_t l2rsp_address,
	output logic load_event,
	output logic store_event
);

	import l2_types_pkg::*;

	l2_state_t state_q;
	l2_state_t state_d;
	l2_op_t op_q; // Latched request tags
	line_addr_t addr_q;
	word_mask_t mask_q;
	core_index_t core_q;
	line_data_t data_q; // Store payload
	logic accept;

	assign l2req_ready = (state_q == IDLE);
	assign accept = l2req_valid && l2req_ready;

	// Next state
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			IDLE:
				if (accept)
					state_d = ACCESS;
			ACCESS:
				if (burst_last)
					state_d = RESPOND; // Last word handled this edge
			RESPOND:
				state_d = IDLE;
			default:
				state_d = IDLE;
		endcase
	end

	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
			state_q <= IDLE;
		else
			state_q <= state_d;
	end

	// Request tags, held for the whole transaction
	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
		begin
			op_q <= L2_OP_LOAD;
			addr_q <= '0;
			mask_q <= '0;
			core_q <= 1'b0;
		end
		else if (accept)
		begin
			op_q <= l2req_op;
			addr_q <= l2req_address;
			mask_q <= l2req_mask;
			core_q <= l2req_core;
		end
	end

	always_ff @(posedge reset)
	begin
		if (accept)
			data_q <= l2req_data; // Core may drop its data after accept
	end

	assign burst_run = (state_q == ACCESS);
	assign word_write_en = burst_run && (op_q == L2_OP_STORE) && mask_q[word_index];
	assign line_addr = addr_q;
	assign write_line = data_q;

	// Response, broadcast to both cores
	assign l2rsp_valid = (state_q == RESPOND);
	assign l2rsp_core = core_q;
	assign l2rsp_op = op_q;
	assign l2rsp_address = addr_q;

	assign load_event = accept && (l2req_op == L2_OP_LOAD);
	assign store_event = accept && (l2req_op == L2_OP_STORE);

endmodule

`default_nettype wire

//--- src/l2_types_pkg.sv
// **************************************************
// Request, response and L2 controller state types
// **************************************************
`default_nettype none

`include "gpgpu_params.svh"

package l2_types_pkg;

	typedef logic [$clog2(`GPGPU_NUM_LINES)-1:0] line_addr_t; // Line address
	typedef logic [`GPGPU_WORD_WIDTH-1:0] word_t; // One data word
	typedef logic [$clog2(`GPGPU_LINE_WORDS)-1:0] word_index_t; // Word inside a line
	typedef logic [`GPGPU_LINE_WORDS*`GPGPU_WORD_WIDTH-1:0] line_data_t; // Word 0 in low bits
	typedef logic [`GPGPU_LINE_WORDS-1:0] word_mask_t; // Per-word store enable
	typedef logic core_index_t; // Requesting core

	typedef logic l2_op_t; // Request operation
	localparam l2_op_t L2_OP_LOAD = 1'b0;
	localparam l2_op_t L2_OP_STORE = 1'b1;

	// Controller sequence per request
	typedef enum logic [1:0]
	{
		IDLE, // Ready for a new request
		ACCESS, // Burst over the line words
		RESPOND // One-cycle response
	} l2_state_t;

endpackage

`default_nettype wire

//--- src/line_store.sv
// **************************************************
// Line memory with masked word writes
// and the response line register
// **************************************************
`default_nettype none

`include "gpgpu_params.svh"

module line_store
(
	input wire logic reset, // Clock
	input wire logic clk, // Async reset, active high
	input wire l2_types_pkg::line_addr_t line_addr,
	input wire l2_types_pkg::word_index_t word_index,
	input wire logic word_write_en,
	input wire l2_types_pkg::line_data_t write_line,
	output l2_types_pkg::line_data_t rsp_line // Whole line after the burst
);

	import l2_types_pkg::*;

	word_t mem [`GPGPU_NUM_LINES][`GPGPU_LINE_WORDS];
	word_t wr_word; // Store data for the current word
	word_t new_word; // Word value after this cycle's write

	assign wr_word = write_line[word_index*`GPGPU_WORD_WIDTH +: `GPGPU_WORD_WIDTH];
	assign new_word = word_write_en ? wr_word : mem[line_addr][word_index];

	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
		begin
			for (int l = 0; l < `GPGPU_NUM_LINES; l++)
			begin
				for (int w = 0; w < `GPGPU_LINE_WORDS; w++)
					mem[l][w] <= '0;
			end
		end
		else if (word_write_en)
			mem[line_addr][word_index] <= wr_word;
	end

	// Slot filled as the burst walks the line, write data passed through
	always_ff @(posedge reset)
	begin
		rsp_line[word_index*`GPGPU_WORD_WIDTH +: `GPGPU_WORD_WIDTH] <= new_word;
	end

endmodule

`default_nettype wire

//--- src/pc_types_pkg.sv
// **************************************************
// Performance counter types and event indices
// **************************************************
`default_nettype none

`include "gpgpu_params.svh"

package pc_types_pkg;

	typedef logic [$clog2(`GPGPU_NUM_COUNTERS)-1:0] pc_index_t; // Counter select
	typedef logic [`GPGPU_COUNTER_WIDTH-1:0] pc_count_t; // Counter value
	typedef logic [`GPGPU_NUM_COUNTERS-1:0] pc_event_vec_t; // One strobe per counter

	// Event positions in pc_event_vec_t
	localparam pc_index_t PC_LOAD = 2'd0; // Loads accepted
	localparam pc_index_t PC_STORE = 2'd1; // Stores accepted
	localparam pc_index_t PC_WORD_WRITE = 2'd2; // Words written
	localparam pc_index_t PC_STALL = 2'd3; // Cycles with a core held off

endpackage

`default_nettype wire

//--- src/performance_counters.sv
// **************************************************
// Event counters with a select-and-read port
// **************************************************
`default_nettype none

`include "gpgpu_params.svh"

module performance_counters
(
	input wire logic reset, // Clock
	input wire logic clk, // Async reset, active high
	input wire pc_types_pkg::pc_event_vec_t pc_event, // One strobe per counter
	input wire pc_types_pkg::pc_index_t pc_select,
	output pc_types_pkg::pc_count_t pc_value
);

	import pc_types_pkg::*;

	pc_count_t count_q [`GPGPU_NUM_COUNTERS];

	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
		begin
			for (int i = 0; i < `GPGPU_NUM_COUNTERS; i++)
				count_q[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < `GPGPU_NUM_COUNTERS; i++)
			begin
				if (pc_event[i])
					count_q[i] <= count_q[i] + 1'b1; // Wraps at full width
			end
		end
	end

	assign pc_value = count_q[pc_select]; // Read mux

endmodule

`default_nettype wire

//--- verification/gpgpu_mem_checker.sv
// **************************************************
// Protocol assertions bound onto the memory side top
// **************************************************
`default_nettype none

module gpgpu_mem_checker
(
	input wire logic reset, // Clock
	input wire logic clk, // Async reset, active high
	input wire logic l2req_valid0,
	input wire logic l2req_ready0,
	input wire logic l2req_valid1,
	input wire logic l2req_ready1,
	input wire logic l2rsp_valid,
	input wire l2_types_pkg::l2_state_t ctrl_state // Controller FSM state
);

	timeunit 1ns;
	timeprecision 100ps;

	import l2_types_pkg::*;

	logic accept; // Transfer on either core port
	int assert_fails = 0; // Failed assertion count

	assign accept = (l2req_valid0 && l2req_ready0) || (l2req_valid1 && l2req_ready1);

	// Response valid is a single pulse
	rsp_pulse_a: assert property (@(posedge reset) disable iff (clk)
		l2rsp_valid |=> !l2rsp_valid)
		else
		begin
			assert_fails++;
			$error("l2rsp_valid high for two cycles in a row");
		end

	// Fixed latency from accept to response
	rsp_latency_a: assert property (@(posedge reset) disable iff (clk)
		accept |-> ##5 l2rsp_valid)
		else
		begin
			assert_fails++;
			$error("No response 5 cycles after an accept");
		end

	// Ready goes to one core only
	ready_onehot_a: assert property (@(posedge reset) disable iff (clk)
		!(l2req_ready0 && l2req_ready1))
		else
		begin
			assert_fails++;
			$error("Both cores see ready in the same cycle");
		end

	// One request in flight at a time
	accept_idle_a: assert property (@(posedge reset) disable iff (clk)
		accept |-> (ctrl_state == IDLE))
		else
		begin
			assert_fails++;
			$error("Request accepted while the controller is busy");
		end

endmodule

`default_nettype wire

//--- verification/gpgpu_mem_tb.sv
// **************************************************
// Testbench: LFSR core traffic, line and counter
// model, typed compare tasks, watchdog
// **************************************************
`default_nettype none

`include "gpgpu_params.svh"

module gpgpu_mem_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import l2_types_pkg::*;
	import pc_types_pkg::*;

	localparam int NUM_TRANS = 400; // Requests issued in total
	localparam int CLK_PERIOD = 10;
	localparam int TIMEOUT_NS = NUM_TRANS * 8 * CLK_PERIOD + 5000; // Plus reset and margin

	logic reset; // Clock
	logic clk; // Async reset
	logic [1:0] valid; // Per-core request signals
	logic [1:0] ready;
	l2_op_t op [2];
	line_addr_t addr [2];
	line_data_t data [2];
	word_mask_t mask [2];
	logic rsp_valid;
	core_index_t rsp_core;
	l2_op_t rsp_op;
	line_addr_t rsp_addr;
	line_data_t rsp_data;
	pc_index_t pc_select;
	pc_count_t pc_value;

	logic [15:0] lfsr_q; // Stimulus generator state
	line_data_t shadow [`GPGPU_NUM_LINES]; // Model of the line store
	pc_count_t exp_count [`GPGPU_NUM_COUNTERS]; // Model counters
	line_data_t exp_line [$]; // Outstanding responses
	line_addr_t exp_addr [$];
	core_index_t exp_core [$];
	l2_op_t exp_op [$];
	int exp_due [$]; // Cycle the response must show up
	logic [1:0] accepted; // Transfer seen at the coming edge
	int passed_over [2]; // Other-core accepts while waiting
	int cycle; // Counted at falling edges after reset
	int issued;
	int value_errors;
	int other_errors;

	gpgpu_mem dut0
	(
		.reset(reset),
		.clk(clk),
		.l2req_valid0(valid[0]),
		.l2req_op0(op[0]),
		.l2req_address0(addr[0]),
		.l2req_data0(data[0]),
		.l2req_mask0(mask[0]),
		.l2req_ready0(ready[0]),
		.l2req_valid1(valid[1]),
		.l2req_op1(op[1]),
		.l2req_address1(addr[1]),
		.l2req_data1(data[1]),
		.l2req_mask1(mask[1]),
		.l2req_ready1(ready[1]),
		.l2rsp_valid(rsp_valid),
		.l2rsp_core(rsp_core),
		.l2rsp_op(rsp_op),
		.l2rsp_address(rsp_addr),
		.l2rsp_data(rsp_data),
		.pc_select(pc_select),
		.pc_value(pc_value)
	);

	bind gpgpu_mem gpgpu_mem_checker checker0
	(
		.reset(reset),
		.clk(clk),
		.l2req_valid0(l2req_valid0),
		.l2req_ready0(l2req_ready0),
		.l2req_valid1(l2req_valid1),
		.l2req_ready1(l2req_ready1),
		.l2rsp_valid(l2rsp_valid),
		.ctrl_state(ctrl0.state_q)
	);

	// Taps 16, 14, 13, 11
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
		lfsr_q = {lfsr_q[14:0], fb};
		return fb;
	endfunction

	function automatic line_data_t take_bits(input int n);
		line_data_t r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[$bits(line_data_t)-2:0], lfsr_step()}; // One step per bit
		return r;
	endfunction

	task automatic check_line(input string name, input line_data_t got, input line_data_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input line_addr_t got, input line_addr_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_core(input string name, input core_index_t got, input core_index_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_op(input string name, input l2_op_t got, input l2_op_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input pc_count_t got, input pc_count_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("ERROR t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string msg);
		other_errors++;
		$display("FAILURE t=%0t %s", $time, msg);
	endtask

	// New request for core c, or none
	task automatic issue_request(input int c);
		if (issued < `GPGPU_NUM_LINES)
		begin
			valid[c] = (c == 0); // Sweep every line with core 0 loads first
			op[c] = L2_OP_LOAD;
			addr[c] = line_addr_t'(issued);
			mask[c] = '0;
			data[c] = '0;
			issued += (c == 0);
		end
		else if (issued < NUM_TRANS && take_bits(2) != 0)
		begin
			valid[c] = 1'b1;
			op[c] = l2_op_t'(take_bits(1));
			addr[c] = line_addr_t'(take_bits($bits(line_addr_t)));
			mask[c] = word_mask_t'(take_bits(`GPGPU_LINE_WORDS));
			data[c] = take_bits($bits(line_data_t));
			issued++;
		end
		else
			valid[c] = 1'b0;
	endtask

	// Model update and expected response for an accept
	task automatic record_accept(input int c);
		line_addr_t a;
		a = addr[c];
		if (op[c] == L2_OP_STORE)
		begin
			exp_count[PC_STORE]++;
			for (int w = 0; w < `GPGPU_LINE_WORDS; w++)
			begin
				if (mask[c][w])
				begin
					shadow[a][w*`GPGPU_WORD_WIDTH +: `GPGPU_WORD_WIDTH] =
						data[c][w*`GPGPU_WORD_WIDTH +: `GPGPU_WORD_WIDTH];
					exp_count[PC_WORD_WRITE]++;
				end
			end
		end
		else
			exp_count[PC_LOAD]++;
		exp_line.push_back(shadow[a]); // Merged line
		exp_addr.push_back(a);
		exp_core.push_back(core_index_t'(c));
		exp_op.push_back(op[c]);
		exp_due.push_back(cycle + 5); // Fixed controller latency
		passed_over[c] = 0;
		if (valid[1-c])
		begin
			passed_over[1-c]++;
			if (passed_over[1-c] >= 2)
				report_failure($sformatf("core %0d waited through two other accepts", 1 - c));
		end
	endtask

	task automatic drop_expected();
		void'(exp_line.pop_front());
		void'(exp_addr.pop_front());
		void'(exp_core.pop_front());
		void'(exp_op.pop_front());
		void'(exp_due.pop_front());
	endtask

	initial
	begin
		reset = 1'b0;
		forever
			#(CLK_PERIOD / 2) reset = !reset;
	end

	// Monitor and model, in the middle of the cycle
	always @(negedge reset)
	begin
		if (!clk)
		begin
			cycle++;
			if (rsp_valid)
			begin
				if (exp_due.size() == 0)
					report_failure("response with no request outstanding");
				else
				begin
					if (exp_due[0] != cycle)
						report_failure($sformatf("response at cycle %0d, due %0d", cycle, exp_due[0]));
					check_line("l2rsp_data", rsp_data, exp_line[0]);
					check_addr("l2rsp_address", rsp_addr, exp_addr[0]);
					check_core("l2rsp_core", rsp_core, exp_core[0]);
					check_op("l2rsp_op", rsp_op, exp_op[0]);
					drop_expected();
				end
			end
			else if (exp_due.size() != 0 && exp_due[0] <= cycle)
			begin
				report_failure("response missing at its due cycle");
				drop_expected();
			end
			if (ready[0] && ready[1])
				report_failure("ready given to both cores");
			if (exp_due.size() != 0 && ready != 2'b00)
				report_failure("ready given while a response is pending");
			if ((valid[0] && !ready[0]) || (valid[1] && !ready[1]))
				exp_count[PC_STALL]++; // Once per cycle
			for (int c = 0; c < 2; c++)
			begin
				accepted[c] = valid[c] && ready[c];
				if (accepted[c])
					record_accept(c);
			end
		end
	end

	// Stimulus, 1 ns after the rising edge
	always @(posedge reset)
	begin
		#1;
		if (cycle > 0)
		begin
			for (int c = 0; c < 2; c++)
			begin
				if (!valid[c] || accepted[c])
					issue_request(c);
			end
		end
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Watchdog: run timed out, %0d value errors, %0d other errors",
			value_errors, other_errors);
		$display("Done: errors found");
		$finish;
	end

	initial
	begin
		lfsr_q = 16'h0001; // Seed
		clk = 1'b1;
		valid = 2'b00;
		accepted = 2'b00;
		pc_select = '0;
		cycle = 0;
		issued = 0;
		value_errors = 0;
		other_errors = 0;
		for (int c = 0; c < 2; c++)
		begin
			op[c] = L2_OP_LOAD;
			addr[c] = '0;
			data[c] = '0;
			mask[c] = '0;
			passed_over[c] = 0;
		end
		for (int l = 0; l < `GPGPU_NUM_LINES; l++)
			shadow[l] = '0;
		for (int i = 0; i < `GPGPU_NUM_COUNTERS; i++)
			exp_count[i] = '0;
		repeat (8) @(posedge reset);
		#1 clk = 1'b0;
		do
			@(posedge reset);
		while (!(issued >= NUM_TRANS && valid == 2'b00 && exp_due.size() == 0));
		for (int i = 0; i < `GPGPU_NUM_COUNTERS; i++)
		begin
			@(posedge reset);
			#1 pc_select = pc_index_t'(i);
			@(negedge reset);
			check_count($sformatf("pc_value[%0d]", i), pc_value, exp_count[i]);
		end
		$display("Checks finished: %0d value errors, %0d other errors, %0d assertion failures",
			value_errors, other_errors, dut0.checker0.assert_fails);
		if (value_errors == 0 && other_errors == 0 && dut0.checker0.assert_fails == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
